//--- design/miniMemPkg.sv
package miniMemPkg;

    // Widths with a meaning of their own
    typedef logic [31:0] tAddr;    // Byte address, core or fabric
    typedef logic [31:0] tData;    // One data word
    typedef logic [7:0]  tTileId;  // Tile number, top byte of an address
    typedef logic [3:0]  tByteEn;  // One bit per byte lane

    // Fabric opcodes
    typedef enum logic [1:0] {
        RD     = 2'd0,
        WR     = 2'd1,
        RD_RSP = 2'd2
    } tOpcode;

    // Fabric transaction, 76 bits over all
    typedef struct packed {
        tAddr       address;
        tData       data;
        tOpcode     opcode;
        tTileId     requestorId;    // Tile that issued the request
        logic [1:0] nextTileArbId;  // Rewritten by the fabric later on
    } tTileTrans;

    // Decoded from address bits 23:22
    typedef enum logic [1:0] {
        REG_IMEM = 2'b00,
        REG_DMEM = 2'b01,
        REG_CR   = 2'b10,
        REG_NONE = 2'b11
    } tRegion;

    // Address map
    localparam int TILE_ID_MSB = 31;
    localparam int TILE_ID_LSB = 24;
    localparam int REGION_MSB  = 23;
    localparam int REGION_LSB  = 22;

    // Sizes
    localparam int IMEM_ADDR_W = 10;  // Word address bits
    localparam int DMEM_ADDR_W = 10;  // Word address bits
    localparam int FIFO_DEPTH  = 2;
    localparam logic [1:0] NULL_ARB_ID = 2'd0;

endpackage

//--- design/dualPortMem.sv
`timescale 1ns/1ps

// Two-port synchronous RAM, byte lanes on both ports
module dualPortMem #(
    parameter int ADDR_W = 10
) (
    input  logic               Clock,
    // Port A
    input  logic [ADDR_W-1:0]  addrA,
    input  miniMemPkg::tData   dataA,
    input  logic               wrEnA,
    input  miniMemPkg::tByteEn byteEnA,
    output miniMemPkg::tData   qA,
    // Port B
    input  logic [ADDR_W-1:0]  addrB,
    input  miniMemPkg::tData   dataB,
    input  logic               wrEnB,
    input  miniMemPkg::tByteEn byteEnB,
    output miniMemPkg::tData   qB
);
    import miniMemPkg::*;

    tData mem [2**ADDR_W];  // Word array

    // Both ports in one process; port B lands last on a collision
    always_ff @(posedge Clock) begin
        for (int i = 0; i < $bits(tByteEn); i++) begin
            if (wrEnA && byteEnA[i]) begin
                mem[addrA][8*i +: 8] <= dataA[8*i +: 8];
            end
            if (wrEnB && byteEnB[i]) begin
                mem[addrB][8*i +: 8] <= dataB[8*i +: 8];
            end
        end
        qA <= mem[addrA];  // Old data on read during write
        qB <= mem[addrB];
    end

endmodule

//--- design/transFifo.sv
`timescale 1ns/1ps

// Small circular FIFO of tile transactions
module transFifo #(
    parameter int DEPTH = miniMemPkg::FIFO_DEPTH
) (
    input  logic                  Clock,
    input  logic                  rstN,
    input  logic                  push,
    input  miniMemPkg::tTileTrans pushData,
    input  logic                  pop,
    output miniMemPkg::tTileTrans popData,
    output logic                  full,
    output logic                  almostFull,
    output logic                  empty
);
    import miniMemPkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    tTileTrans        entries [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;   // Occupied entries
    logic             doPush;
    logic             doPop;

    assign doPush = push && !full;  // Push into a full FIFO is dropped
    assign doPop  = pop && !empty;

    // Entry storage
    always_ff @(posedge Clock) begin
        if (doPush) begin
            entries[wrPtr] <= pushData;
        end
    end

    // Pointers and count
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;  // Wrap
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    assign popData    = entries[rdPtr];               // Head, no read latency
    assign full       = (count == CNT_W'(DEPTH));
    assign almostFull = (count >= CNT_W'(DEPTH - 1)); // One slot or less free
    assign empty      = (count == '0);

endmodule

//--- design/rrArbiter.sv
`timescale 1ns/1ps

// Two-client round robin, combinational grant
module rrArbiter (
    input  logic       Clock,
    input  logic       rstN,
    input  logic [1:0] candidate,  // Bit 0 rsp FIFO, bit 1 req FIFO
    output logic [1:0] grant       // One-hot
);

    logic lastWinner;  // Index of previous winner

    // Tie goes to the client that lost last time
    always_comb begin
        if (&candidate) begin
            grant = lastWinner ? 2'b01 : 2'b10;
        end else begin
            grant = candidate;  // Zero or one requester
        end
    end

    // Only moves on an actual grant
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            lastWinner <= 1'b1;  // Client 0 first out of reset
        end else if (|grant) begin
            lastWinner <= grant[1];
        end
    end

endmodule

//--- design/tileCfgRegs.sv
`timescale 1ns/1ps

// Tile control registers, fabric side only
module tileCfgRegs (
    input  logic               Clock,
    input  logic               rstN,
    input  logic               wrEn,
    input  miniMemPkg::tData   wrData,
    input  logic               rdEn,
    output miniMemPkg::tData   rdData,
    output miniMemPkg::tTileId localTileId
);
    import miniMemPkg::*;

    tTileId tileIdReg;  // CR word 0

    // Tile id, steers core locality
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            tileIdReg <= '0;
        end else if (wrEn) begin
            tileIdReg <= wrData[$bits(tTileId)-1:0];  // Low byte only
        end
    end

    // One cycle read, same timing as the memories
    always_ff @(posedge Clock) begin
        if (rdEn) begin
            rdData <= tData'(tileIdReg);  // Zero extended
        end
    end

    assign localTileId = tileIdReg;

endmodule

//--- design/miniMemWrap.sv
`timescale 1ns/1ps

module miniMemWrap (
    input  logic                  Clock,
    input  logic                  rstN,
    // Core fetch
    input  miniMemPkg::tAddr      PcQ100H,
    output miniMemPkg::tData      PreInstructionQ101H,
    // Core data
    input  miniMemPkg::tData      DMemWrDataQ103H,
    input  miniMemPkg::tAddr      DMemAddressQ103H,
    input  miniMemPkg::tByteEn    DMemByteEnQ103H,
    input  logic                  DMemWrEnQ103H,
    input  logic                  DMemRdEnQ103H,
    output miniMemPkg::tData      DMemRdRspQ104H,
    // Fabric
    input  logic                  InFabricValidQ503H,
    input  miniMemPkg::tTileTrans InFabricQ503H,
    output logic                  miniCoreReady,
    output logic                  OutFabricValidQ505H,
    output miniMemPkg::tTileTrans OutFabricQ505H,
    input  logic                  fabReady
);
    import miniMemPkg::*;

    tTileId    localTileId;
    logic      localCoreQ103H, nonLocalReqQ103H, localWrEnQ103H, localRdQ103H;
    tData      shiftWrDataQ103H;
    tByteEn    shiftByteEnQ103H;
    tTileTrans reqTransQ103H;
    logic [1:0] offsetQ104H;
    logic      coreRdHitQ104H;
    tData      dmemRdDataQ104H;
    tRegion    fabRegionQ503H, fabRegionQ504H;
    logic      fabWrQ503H, fabRdQ503H;
    logic      imemWrEnQ503H, dmemWrEnQ503H, cfgWrEnQ503H, cfgRdEnQ503H;
    logic      rspValidQ504H;
    tAddr      rspAddrQ504H;
    tData      imemRdDataQ504H, dmemFabDataQ504H, cfgRdDataQ504H, rspDataQ504H;
    tTileTrans rspTransQ504H, rspHead, reqHead;
    logic      rspEmpty, rspAlmostFull, reqEmpty, reqFull;
    logic [1:0] candidate, grant;

    //==================================================================
    // Core data side, Q103
    //==================================================================
    // Tile 0 is always an alias for this tile
    assign localCoreQ103H   = (DMemAddressQ103H[TILE_ID_MSB:TILE_ID_LSB] == localTileId) ||
                              (DMemAddressQ103H[TILE_ID_MSB:TILE_ID_LSB] == '0);
    assign localWrEnQ103H   = DMemWrEnQ103H && localCoreQ103H;
    assign localRdQ103H     = DMemRdEnQ103H && localCoreQ103H;
    assign nonLocalReqQ103H = (DMemWrEnQ103H || DMemRdEnQ103H) && !localCoreQ103H;

    // Byte and halfword write alignment
    assign shiftWrDataQ103H = DMemWrDataQ103H << {DMemAddressQ103H[1:0], 3'b000};
    assign shiftByteEnQ103H = DMemByteEnQ103H << DMemAddressQ103H[1:0];

    always_ff @(posedge Clock) begin
        offsetQ104H <= DMemAddressQ103H[1:0];  // Read realign at Q104
    end

    // Shift back down, zero filled; non-local reads return nothing
    assign DMemRdRspQ104H = coreRdHitQ104H ? (dmemRdDataQ104H >> {offsetQ104H, 3'b000}) : '0;

    // Outgoing core request, data left unshifted
    always_comb begin
        reqTransQ103H.address       = DMemAddressQ103H;
        reqTransQ103H.data          = DMemWrDataQ103H;
        reqTransQ103H.opcode        = DMemWrEnQ103H ? WR : RD;
        reqTransQ103H.requestorId   = localTileId;
        reqTransQ103H.nextTileArbId = NULL_ARB_ID;
    end

    //==================================================================
    // Fabric side, Q503
    //==================================================================
    assign fabRegionQ503H = tRegion'(InFabricQ503H.address[REGION_MSB:REGION_LSB]);
    assign fabWrQ503H     = InFabricValidQ503H && (InFabricQ503H.opcode == WR);
    assign fabRdQ503H     = InFabricValidQ503H && (InFabricQ503H.opcode == RD);  // RD_RSP dropped
    assign imemWrEnQ503H  = fabWrQ503H && (fabRegionQ503H == REG_IMEM);
    assign dmemWrEnQ503H  = fabWrQ503H && (fabRegionQ503H == REG_DMEM);
    assign cfgWrEnQ503H   = fabWrQ503H && (fabRegionQ503H == REG_CR);  // All CR offsets hit word 0
    assign cfgRdEnQ503H   = fabRdQ503H && (fabRegionQ503H == REG_CR);

    // Response address points back at the requestor
    always_ff @(posedge Clock) begin
        rspAddrQ504H <= {InFabricQ503H.requestorId, InFabricQ503H.address[TILE_ID_LSB-1:0]};
    end

    // Hit flags to Q104 / Q504
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            coreRdHitQ104H <= 1'b0;
            rspValidQ504H  <= 1'b0;
            fabRegionQ504H <= REG_NONE;
        end else begin
            coreRdHitQ104H <= localRdQ103H;
            rspValidQ504H  <= fabRdQ503H;
            fabRegionQ504H <= fabRegionQ503H;
        end
    end

    // Read response data select
    always_comb begin
        case (fabRegionQ504H)
            REG_IMEM: rspDataQ504H = imemRdDataQ504H;
            REG_DMEM: rspDataQ504H = dmemFabDataQ504H;
            REG_CR:   rspDataQ504H = cfgRdDataQ504H;
            default:  rspDataQ504H = '0;  // Unmapped region
        endcase
        rspTransQ504H.address       = rspAddrQ504H;
        rspTransQ504H.data          = rspDataQ504H;
        rspTransQ504H.opcode        = RD_RSP;
        rspTransQ504H.requestorId   = localTileId;
        rspTransQ504H.nextTileArbId = NULL_ARB_ID;
    end

    dualPortMem #(.ADDR_W(IMEM_ADDR_W)) uIMem (
        .Clock   (Clock),
        .addrA   (PcQ100H[IMEM_ADDR_W+1:2]),  // Fetch only
        .dataA   ('0),
        .wrEnA   (1'b0),
        .byteEnA ('0),
        .qA      (PreInstructionQ101H),
        .addrB   (InFabricQ503H.address[IMEM_ADDR_W+1:2]),
        .dataB   (InFabricQ503H.data),
        .wrEnB   (imemWrEnQ503H),
        .byteEnB ('1),                         // Full words from the fabric
        .qB      (imemRdDataQ504H)
    );

    dualPortMem #(.ADDR_W(DMEM_ADDR_W)) uDMem (
        .Clock   (Clock),
        .addrA   (DMemAddressQ103H[DMEM_ADDR_W+1:2]),
        .dataA   (shiftWrDataQ103H),
        .wrEnA   (localWrEnQ103H),
        .byteEnA (shiftByteEnQ103H),
        .qA      (dmemRdDataQ104H),
        .addrB   (InFabricQ503H.address[DMEM_ADDR_W+1:2]),
        .dataB   (InFabricQ503H.data),
        .wrEnB   (dmemWrEnQ503H),
        .byteEnB ('1),
        .qB      (dmemFabDataQ504H)
    );

    tileCfgRegs uCfg (
        .Clock       (Clock),
        .rstN        (rstN),
        .wrEn        (cfgWrEnQ503H),
        .wrData      (InFabricQ503H.data),
        .rdEn        (cfgRdEnQ503H),
        .rdData      (cfgRdDataQ504H),
        .localTileId (localTileId)
    );

    //==================================================================
    // Outgoing fabric port
    //==================================================================
    transFifo #(.DEPTH(FIFO_DEPTH)) uRspFifo (
        .Clock      (Clock),
        .rstN       (rstN),
        .push       (rspValidQ504H),
        .pushData   (rspTransQ504H),
        .pop        (grant[0]),
        .popData    (rspHead),
        .full       (),
        .almostFull (rspAlmostFull),  // Margin for the Q504 push
        .empty      (rspEmpty)
    );

    transFifo #(.DEPTH(FIFO_DEPTH)) uReqFifo (
        .Clock      (Clock),
        .rstN       (rstN),
        .push       (nonLocalReqQ103H),
        .pushData   (reqTransQ103H),
        .pop        (grant[1]),
        .popData    (reqHead),
        .full       (reqFull),
        .almostFull (),
        .empty      (reqEmpty)
    );

    assign candidate[0] = !rspEmpty && fabReady;  // Fabric back-pressure
    assign candidate[1] = !reqEmpty && fabReady;

    rrArbiter uArb (
        .Clock     (Clock),
        .rstN      (rstN),
        .candidate (candidate),
        .grant     (grant)
    );

    assign OutFabricValidQ505H = |grant;
    assign OutFabricQ505H      = grant[0] ? rspHead :
                                 grant[1] ? reqHead : '0;

    assign miniCoreReady = !rspAlmostFull && !reqFull;

endmodule

//--- verification/miniMemWrap_chk.sv
`timescale 1ns/1ps

// Protocol checks on the wrapper internals
module miniMemWrapChk (
    input logic       Clock,
    input logic       rstN,
    input logic       miniCoreReady,
    input logic [1:0] candidate,
    input logic [1:0] grant,
    input logic       fabRdQ503H,
    input logic       nonLocalReqQ103H,
    input logic       reqFull
);

    // Back-to-back contention alternates the winner
    aArbAlternate: assert property (@(posedge Clock) disable iff (!rstN)
        (&candidate && $past(&candidate)) |-> (grant != $past(grant)))
        else $error("Arbiter granted the same client twice under contention");

    aFabricPush: assert property (@(posedge Clock) disable iff (!rstN)
        fabRdQ503H |-> miniCoreReady)
        else $error("Fabric read issued while not ready");

    aReqPush: assert property (@(posedge Clock) disable iff (!rstN)
        nonLocalReqQ103H |-> !reqFull)
        else $error("Core request pushed into a full request FIFO");

endmodule

bind miniMemWrap miniMemWrapChk uChk (
    .Clock            (Clock),
    .rstN             (rstN),
    .miniCoreReady    (miniCoreReady),
    .candidate        (candidate),
    .grant            (grant),
    .fabRdQ503H       (fabRdQ503H),
    .nonLocalReqQ103H (nonLocalReqQ103H),
    .reqFull          (reqFull)
);

//--- verification/miniMemWrapTb.sv
`timescale 1ns/1ps

module miniMemWrapTb;
    import miniMemPkg::*;

    localparam int TIMEOUT_CYCLES = 2000;  // Generous margin over all tests together

    logic      Clock, rstN, fabReady;
    tAddr      PcQ100H, DMemAddressQ103H;
    tData      PreInstructionQ101H, DMemWrDataQ103H, DMemRdRspQ104H;
    tByteEn    DMemByteEnQ103H;
    logic      DMemWrEnQ103H, DMemRdEnQ103H, InFabricValidQ503H;
    tTileTrans InFabricQ503H, OutFabricQ505H;
    logic      miniCoreReady, OutFabricValidQ505H;

    tData      imemModel [2**IMEM_ADDR_W];  // Mirrors of both memories
    tData      dmemModel [2**DMEM_ADDR_W];
    tTileTrans outQ [$];                    // Everything popped onto the fabric
    tTileId    tileId;                      // Expected localTileId
    int        cycleCount;

    miniMemWrap u_miniMemWrap (.*);

    always #4 Clock = ~Clock;

    // Sampled on the edge that pops the winner
    always @(posedge Clock) begin
        if (rstN && OutFabricValidQ505H) begin
            outQ.push_back(OutFabricQ505H);
        end
    end

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount == TIMEOUT_CYCLES) begin
            abortRun("Timeout, the tests did not complete within the cycle limit");
        end
    end

    //======================================================================
    // Helpers and compare tasks
    //======================================================================
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped on the first failure");
    endtask

    task automatic checkData(input string testName, input tData expVal, input tData actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("ERROR %s expected %h actual %h", testName, expVal, actVal));
        end
    endtask

    task automatic checkTrans(input string testName, input tTileTrans expVal,
                              input tTileTrans actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("ERROR %s expected %h actual %h", testName, expVal, actVal));
        end
    endtask

    task automatic checkFlag(input string testName, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("ERROR %s expected %b actual %b", testName, expVal, actVal));
        end
    endtask

    function automatic tAddr regionAddr(input tTileId tile, input tRegion region, input int word);
        return {tile, region, 10'b0, 10'(word), 2'b00};  // Word index in bits 11:2
    endfunction

    function automatic tTileTrans makeTrans(input tAddr addr, input tData data,
                                            input tOpcode op, input tTileId reqId);
        return '{address: addr, data: data, opcode: op, requestorId: reqId,
                 nextTileArbId: NULL_ARB_ID};
    endfunction

    // Shifted byte lanes of a core write
    function automatic tData mergeWrite(input tData old, input tData data, input tByteEn be,
                                        input logic [1:0] off);
        tData   shData;
        tByteEn shBe;
        tData   result;
        shData = data << (8 * off);
        shBe   = be << off;
        result = old;
        for (int i = 0; i < 4; i++) begin
            if (shBe[i]) begin
                result[8*i +: 8] = shData[8*i +: 8];
            end
        end
        return result;
    endfunction

    task automatic stepCycle();
        @(negedge Clock);               // All inputs move here
        DMemWrEnQ103H      = 1'b0;
        DMemRdEnQ103H      = 1'b0;
        InFabricValidQ503H = 1'b0;
    endtask

    task automatic waitReady();
        while (!miniCoreReady) begin
            @(negedge Clock);
        end
    endtask

    task automatic setCore(input tAddr addr, input tData data, input tByteEn be, input logic wr);
        DMemAddressQ103H = addr;
        DMemWrDataQ103H  = data;
        DMemByteEnQ103H  = be;
        DMemWrEnQ103H    = wr;
        DMemRdEnQ103H    = !wr;
    endtask

    task automatic setFabric(input tOpcode op, input tAddr addr, input tData data,
                             input tTileId reqId);
        InFabricQ503H      = makeTrans(addr, data, op, reqId);
        InFabricValidQ503H = 1'b1;
    endtask

    task automatic coreWrite(input tAddr addr, input tData data, input tByteEn be);
        waitReady();
        setCore(addr, data, be, 1'b1);
        stepCycle();
    endtask

    task automatic coreRead(input tAddr addr);
        waitReady();
        setCore(addr, '0, '0, 1'b0);
        stepCycle();                    // Response now on DMemRdRspQ104H
    endtask

    task automatic fabricSend(input tOpcode op, input tAddr addr, input tData data,
                              input tTileId reqId);
        waitReady();
        setFabric(op, addr, data, reqId);
        stepCycle();
    endtask

    task automatic waitOutput(output tTileTrans t);
        while (outQ.size() == 0) begin
            @(negedge Clock);
        end
        t = outQ.pop_front();
    endtask

    task automatic fabricReadCheck(input string testName, input tAddr addr,
                                   input tTileId reqId, input tData expData);
        tTileTrans got;
        fabricSend(RD, addr, '0, reqId);
        waitOutput(got);
        checkTrans(testName, makeTrans({reqId, addr[23:0]}, expData, RD_RSP, tileId), got);
    endtask

    //======================================================================
    // Directed tests
    //======================================================================
    task automatic testImemFetch();
        int   words [8];
        tData data;
        for (int i = 0; i < 8; i++) begin
            words[i] = int'($urandom % 1024);
            data     = $urandom;
            imemModel[words[i]] = data;
            fabricSend(WR, regionAddr(8'h00, REG_IMEM, words[i]), data, 8'h00);
        end
        for (int i = 0; i < 8; i++) begin
            PcQ100H = tAddr'(words[i] << 2);
            stepCycle();                // Fetch is back one cycle later
            checkData("imemFetch", imemModel[words[i]], PreInstructionQ101H);
        end
    endtask

    task automatic testDmemAlign();
        tAddr   base;
        tData   data;
        tByteEn be;
        int     w;
        for (int i = 0; i < 4; i++) begin
            w    = 16 + i;
            base = tAddr'(w << 2);      // Tile bits 0 so always local
            data = $urandom;
            dmemModel[w] = data;
            coreWrite(base, data, 4'hF);
            for (int off = 0; off < 4; off++) begin
                data = $urandom;
                be   = (i[0] && !off[0]) ? 4'b0011 : 4'b0001;  // Halfwords on even offsets
                dmemModel[w] = mergeWrite(dmemModel[w], data, be, off[1:0]);
                coreWrite(base + tAddr'(off), data, be);
                coreRead(base + tAddr'(off));
                checkData("dmemAlign", dmemModel[w] >> (8 * off), DMemRdRspQ104H);
            end
        end
    endtask

    task automatic testFabricRead();
        tTileId reqId;
        tData   data;
        reqId = 8'($urandom);
        data  = $urandom;
        dmemModel[40] = data;
        fabricSend(WR, regionAddr(tileId, REG_DMEM, 40), data, reqId);
        fabricReadCheck("fabricRead dmem", regionAddr(tileId, REG_DMEM, 40), reqId, data);
        fabricReadCheck("fabricRead core", regionAddr(tileId, REG_DMEM, 17), reqId,
                        dmemModel[17]);
        data = $urandom;
        imemModel[100] = data;
        fabricSend(WR, regionAddr(tileId, REG_IMEM, 100), data, reqId);
        fabricReadCheck("fabricRead imem", regionAddr(tileId, REG_IMEM, 100), reqId, data);
        fabricReadCheck("fabricRead cr", regionAddr(tileId, REG_CR, 0), reqId, tData'(tileId));
        fabricReadCheck("fabricRead none", regionAddr(tileId, REG_NONE, 5), reqId, '0);
    endtask

    task automatic testLocality();
        tTileTrans got;
        tAddr      addr;
        tData      data;
        tTileId    otherId;
        tileId  = 8'h80 | 8'($urandom % 64);  // Never 0
        otherId = tileId + 8'd1;
        fabricSend(WR, regionAddr(8'h00, REG_CR, 0), tData'(tileId), 8'h00);
        fabricReadCheck("locality cr", regionAddr(8'h00, REG_CR, 0), 8'h11, tData'(tileId));
        addr = {tileId, 24'h000050};    // Word 20
        data = $urandom;
        dmemModel[20] = data;
        coreWrite(addr, data, 4'hF);
        coreRead(addr);
        checkData("locality own", data, DMemRdRspQ104H);
        coreRead(tAddr'(20 << 2));      // Tile 0 alias
        checkData("locality alias", data, DMemRdRspQ104H);
        repeat (4) stepCycle();
        if (outQ.size() != 0) begin
            abortRun("A local core access showed up on the fabric output");
        end
        // Another tile's address leaves as a request
        addr = {otherId, 24'h000053};   // Byte offset 3 so a shifted payload would show
        data = $urandom;
        coreWrite(addr, data, 4'hF);
        waitOutput(got);
        checkTrans("locality remote wr", makeTrans(addr, data, WR, tileId), got);
        coreRead(addr);
        waitOutput(got);
        checkTrans("locality remote rd", makeTrans(addr, '0, RD, tileId), got);
        coreRead(tAddr'(20 << 2));
        checkData("locality untouched", dmemModel[20], DMemRdRspQ104H);
    endtask

    task automatic testBackPressure();
        tTileTrans expReq [$];
        tTileTrans gotReq [$];
        tTileTrans gotRsp [$];
        tTileTrans expRsp;
        tTileTrans got;
        tAddr      remote;
        tData      data;
        tTileId    reqId;
        remote = {tileId + 8'd2, 24'h000100};
        reqId  = 8'($urandom);
        data   = $urandom;
        fabReady = 1'b0;
        waitReady();
        setCore(remote, data, 4'hF, 1'b1);  // Core and fabric in the same cycle
        setFabric(RD, regionAddr(tileId, REG_DMEM, 40), '0, reqId);
        expReq.push_back(makeTrans(remote, data, WR, tileId));
        expRsp = makeTrans({reqId, 24'(regionAddr(tileId, REG_DMEM, 40))}, dmemModel[40],
                           RD_RSP, tileId);
        stepCycle();
        waitReady();
        setCore(remote + 32'd4, '0, '0, 1'b0);
        expReq.push_back(makeTrans(remote + 32'd4, '0, RD, tileId));
        repeat (4) stepCycle();
        checkFlag("backPressure ready low", 1'b0, miniCoreReady);
        if (outQ.size() != 0) begin
            abortRun("Output went valid while fabReady was low");
        end
        fabReady = 1'b1;
        for (int i = 0; i < 3; i++) begin
            waitOutput(got);
            if (got.opcode == RD_RSP) begin
                gotRsp.push_back(got);
            end else begin
                gotReq.push_back(got);
            end
        end
        repeat (4) stepCycle();
        if (outQ.size() != 0 || gotReq.size() != 2 || gotRsp.size() != 1) begin
            abortRun("Queued transactions did not come out exactly once each");
        end else begin
            checkTrans("backPressure rsp", expRsp, gotRsp[0]);
            checkTrans("backPressure req0", expReq[0], gotReq[0]);
            checkTrans("backPressure req1", expReq[1], gotReq[1]);
            checkFlag("backPressure ready high", 1'b1, miniCoreReady);
        end
    endtask

    //======================================================================
    // Main sequence
    //======================================================================
    initial begin
        void'($urandom(32'h415a191f));
        Clock              = 1'b0;
        rstN               = 1'b0;
        fabReady           = 1'b1;
        PcQ100H            = '0;
        DMemAddressQ103H   = '0;
        DMemWrDataQ103H    = '0;
        DMemByteEnQ103H    = '0;
        DMemWrEnQ103H      = 1'b0;
        DMemRdEnQ103H      = 1'b0;
        InFabricValidQ503H = 1'b0;
        InFabricQ503H      = '0;
        tileId             = '0;
        cycleCount         = 0;
        repeat (5) @(negedge Clock);    // Reset over 5 rising edges
        rstN = 1'b1;
        checkFlag("reset valid", 1'b0, OutFabricValidQ505H);
        checkFlag("reset ready", 1'b1, miniCoreReady);
        testImemFetch();
        testDmemAlign();
        testFabricRead();
        testLocality();
        testBackPressure();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- miniMemTile.f
design/miniMemPkg.sv
design/dualPortMem.sv
design/transFifo.sv
design/rrArbiter.sv
design/tileCfgRegs.sv
design/miniMemWrap.sv
verification/miniMemWrap_chk.sv
verification/miniMemWrapTb.sv

//--- runSim.sh
#!/bin/sh
# Build with Verilator and run; the exit status is the simulation result
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module miniMemWrapTb \
    -f miniMemTile.f -o miniMemWrapSim &&
./obj_dir/miniMemWrapSim || exit 1
